// File: common/noc_input_port_cfg.svh
`ifndef NOC_INPUT_PORT_CFG_SVH
`define NOC_INPUT_PORT_CFG_SVH

// ------------------------------
// port sizes
// ------------------------------
`define NIP_FLIT_W     256
`define NIP_VC_NUM     4
`define NIP_VC_DEPTH   4 // entries per vc, one upstream credit each

// node id is {x[1:0], y[1:0], port[1:0], device}
`define NIP_NODE_ID_W  7
`define NIP_TXN_ID_W   12
`define NIP_ROUTE_W    3

// ------------------------------
// header bit positions in a flit
// ------------------------------
`define NIP_DST_LSB    4 // bits below the destination id carry the qos value
`define NIP_SRC_LSB    11
`define NIP_TXN_LSB    18

`endif

// File: common/noc_input_port_pkg.sv
`default_nettype none

`include "noc_input_port_cfg.svh"

package noc_input_port_pkg;

	// ------------------------------
	// payload and header fields
	// ------------------------------
	typedef logic [`NIP_FLIT_W-1:0]    flit_t;
	typedef logic [`NIP_NODE_ID_W-1:0] node_id_t;
	typedef logic [`NIP_TXN_ID_W-1:0]  txn_id_t;
	typedef logic [`NIP_ROUTE_W-1:0]   route_t;

	// qos value sits in the flit bits under the destination id
	typedef logic [`NIP_DST_LSB-1:0]   qos_t;

	// ------------------------------
	// virtual channel bookkeeping
	// ------------------------------
	typedef logic [$clog2(`NIP_VC_NUM)-1:0]     vc_id_t;
	typedef logic [`NIP_VC_NUM-1:0]             vc_mask_t; // one bit per vc
	typedef logic [$clog2(`NIP_VC_DEPTH)-1:0]   vc_ptr_t;
	typedef logic [$clog2(`NIP_VC_DEPTH+1)-1:0] vc_cnt_t;  // 0 up to full

	// compact control word seen by switch allocation
	typedef struct packed {
		node_id_t dst_id;
		node_id_t src_id;
		txn_id_t  txn_id;
		route_t   route;    // look-ahead route for the next hop
		qos_t     qos;
	} flit_ctrl_t;

endpackage

`default_nettype wire

// File: input_port/flit_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_input_port_cfg.svh"

module flit_decoder import noc_input_port_pkg::*; (
	input  wire logic   rx_flit_v_i,
	input  wire flit_t  rx_flit_i,
	input  wire vc_id_t rx_vc_id_i,
	input  wire route_t rx_route_i,
	output vc_mask_t    wr_mask_o,
	output flit_ctrl_t  wr_ctrl_o
);

	// ------------------------------
	// header field extraction
	// ------------------------------

	// the word is built every cycle, the write mask decides whether it is stored
	always_comb begin
		wr_ctrl_o.dst_id = rx_flit_i[`NIP_DST_LSB +: `NIP_NODE_ID_W];
		wr_ctrl_o.src_id = rx_flit_i[`NIP_SRC_LSB +: `NIP_NODE_ID_W];
		wr_ctrl_o.txn_id = rx_flit_i[`NIP_TXN_LSB +: `NIP_TXN_ID_W];
		wr_ctrl_o.route  = rx_route_i; // travels beside the flit, not inside it
		wr_ctrl_o.qos    = rx_flit_i[`NIP_DST_LSB-1:0];
	end

	// ------------------------------
	// write steering
	// ------------------------------

	// one-hot on the addressed vc, all zeros on an idle cycle
	always_comb begin
		wr_mask_o = '0;
		if (rx_flit_v_i) begin
			wr_mask_o[rx_vc_id_i] = 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: input_port/vc_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_input_port_cfg.svh"

module vc_buffer import noc_input_port_pkg::*; (
	input  wire logic       clk,
	input  wire logic       rst_n_i,
	input  wire logic       wr_en_i,
	input  wire flit_ctrl_t wr_ctrl_i,
	input  wire flit_t      wr_flit_i,
	input  wire logic       sa_pop_i,
	input  wire logic       st_pop_i,
	output logic            ctrl_vld_o,
	output flit_ctrl_t      ctrl_head_o,
	output flit_t           data_head_o
);

	// ------------------------------
	// storage
	// ------------------------------

	// control word and flit share one slot, so a single write pointer serves both
	flit_ctrl_t ctrl_mem [`NIP_VC_DEPTH];
	flit_t      data_mem [`NIP_VC_DEPTH];

	vc_ptr_t wr_ptr;
	vc_ptr_t ctrl_rd_ptr; // next control word for switch allocation
	vc_ptr_t data_rd_ptr; // next flit for switch traversal, trails ctrl_rd_ptr
	vc_cnt_t ctrl_cnt;    // control words written but not yet popped by sa

	logic sa_fire;

	function automatic vc_ptr_t ptr_inc(input vc_ptr_t ptr);
		if (ptr == vc_ptr_t'(`NIP_VC_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign ctrl_vld_o = (ctrl_cnt != '0);
	assign sa_fire    = sa_pop_i & ctrl_vld_o; // an sa pop of an empty vc is dropped

	always_ff @(posedge clk) begin
		if (wr_en_i) begin
			ctrl_mem[wr_ptr] <= wr_ctrl_i;
			data_mem[wr_ptr] <= wr_flit_i;
		end
	end

	// ------------------------------
	// pointers
	// ------------------------------

	// the upstream credits keep the write pointer from lapping the data read pointer
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_ptr <= '0;
		end else if (wr_en_i) begin
			wr_ptr <= ptr_inc(wr_ptr);
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ctrl_rd_ptr <= '0;
		end else if (sa_fire) begin
			ctrl_rd_ptr <= ptr_inc(ctrl_rd_ptr);
		end
	end

	// st only reads slots whose control word has already left through sa
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			data_rd_ptr <= '0;
		end else if (st_pop_i) begin
			data_rd_ptr <= ptr_inc(data_rd_ptr);
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ctrl_cnt <= '0;
		end else begin
			case ({wr_en_i, sa_fire})
				2'b10:   ctrl_cnt <= ctrl_cnt + 1'b1;
				2'b01:   ctrl_cnt <= ctrl_cnt - 1'b1;
				default: ctrl_cnt <= ctrl_cnt; // both or neither leave the count alone
			endcase
		end
	end

	// ------------------------------
	// heads
	// ------------------------------
	assign ctrl_head_o = ctrl_mem[ctrl_rd_ptr];
	assign data_head_o = data_mem[data_rd_ptr];

endmodule

`default_nettype wire

// File: input_port/vc_read_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_input_port_cfg.svh"

module vc_read_ctrl import noc_input_port_pkg::*; (
	input  wire logic                       st_rd_en_i,
	input  wire vc_id_t                     st_rd_vc_i,
	input  wire logic                       sa_rd_en_i,
	input  wire vc_id_t                     sa_rd_vc_i,
	input  wire flit_t [`NIP_VC_NUM-1:0]    data_heads_i,
	output vc_mask_t                        sa_pop_o,
	output vc_mask_t                        st_pop_o,
	output flit_t                           st_data_o,
	output logic                            lcrd_v_o,
	output vc_id_t                          lcrd_id_o
);

	// ------------------------------
	// pop decode
	// ------------------------------

	always_comb begin
		sa_pop_o = '0;
		sa_pop_o[sa_rd_vc_i] = sa_rd_en_i;
	end

	always_comb begin
		st_pop_o = '0;
		st_pop_o[st_rd_vc_i] = st_rd_en_i;
	end

	// ------------------------------
	// st data select
	// ------------------------------

	// the head is shown whether or not the read is enabled, st samples it with the pop
	assign st_data_o = data_heads_i[st_rd_vc_i];

	// ------------------------------
	// credit return
	// ------------------------------

	// every st read frees one slot, so one credit goes straight back upstream
	assign lcrd_v_o  = st_rd_en_i;
	assign lcrd_id_o = st_rd_vc_i;

endmodule

`default_nettype wire

// File: design/noc_input_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_input_port_cfg.svh"

module noc_input_port import noc_input_port_pkg::*; (
	input  wire logic                        clk,
	input  wire logic                        rst_n_i,

	// receive side, flow controlled by credits only
	input  wire logic                        rx_flit_v_i,
	input  wire flit_t                       rx_flit_i,
	input  wire vc_id_t                      rx_vc_id_i,
	input  wire route_t                      rx_route_i,

	output logic                             lcrd_v_o,
	output vc_id_t                           lcrd_id_o,

	// switch allocation
	output vc_mask_t                         ctrl_head_vld_o,
	output flit_ctrl_t [`NIP_VC_NUM-1:0]     ctrl_head_o,
	input  wire logic                        sa_rd_en_i,
	input  wire vc_id_t                      sa_rd_vc_i,

	// switch traversal
	input  wire logic                        st_rd_en_i,
	input  wire vc_id_t                      st_rd_vc_i,
	output flit_t                            st_data_o
);

	vc_mask_t                    wr_mask;
	flit_ctrl_t                  wr_ctrl;
	vc_mask_t                    sa_pop;
	vc_mask_t                    st_pop;
	flit_t [`NIP_VC_NUM-1:0]     data_heads;

	// ------------------------------
	// write path
	// ------------------------------
	flit_decoder u_flit_decoder (
		.rx_flit_v_i (rx_flit_v_i),
		.rx_flit_i   (rx_flit_i),
		.rx_vc_id_i  (rx_vc_id_i),
		.rx_route_i  (rx_route_i),
		.wr_mask_o   (wr_mask),
		.wr_ctrl_o   (wr_ctrl)
	);

	// ------------------------------
	// per-vc storage
	// ------------------------------
	for (genvar i = 0; i < `NIP_VC_NUM; i++) begin : gen_vc
		vc_buffer u_vc_buffer (
			.clk         (clk),
			.rst_n_i     (rst_n_i),
			.wr_en_i     (wr_mask[i]),
			.wr_ctrl_i   (wr_ctrl),
			.wr_flit_i   (rx_flit_i), // raw flit, every vc sees it
			.sa_pop_i    (sa_pop[i]),
			.st_pop_i    (st_pop[i]),
			.ctrl_vld_o  (ctrl_head_vld_o[i]),
			.ctrl_head_o (ctrl_head_o[i]),
			.data_head_o (data_heads[i])
		);
	end

	// ------------------------------
	// read path
	// ------------------------------
	vc_read_ctrl u_vc_read_ctrl (
		.st_rd_en_i   (st_rd_en_i),
		.st_rd_vc_i   (st_rd_vc_i),
		.sa_rd_en_i   (sa_rd_en_i),
		.sa_rd_vc_i   (sa_rd_vc_i),
		.data_heads_i (data_heads),
		.sa_pop_o     (sa_pop),
		.st_pop_o     (st_pop),
		.st_data_o    (st_data_o),
		.lcrd_v_o     (lcrd_v_o),
		.lcrd_id_o    (lcrd_id_o)
	);

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk
);

	localparam real HALF_PERIOD = 4.0; // 8 ns period

	initial begin
		clk = 1'b0;
		forever begin
			#HALF_PERIOD clk = ~clk;
		end
	end

endmodule

`default_nettype wire

// File: tb/tb_noc_input_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_input_port_cfg.svh"

module tb_noc_input_port import noc_input_port_pkg::*; ();

	logic                         clk;
	logic                         rst_n;
	logic                         rx_flit_v;
	flit_t                        rx_flit;
	vc_id_t                       rx_vc_id;
	route_t                       rx_route;
	logic                         lcrd_v;
	vc_id_t                       lcrd_id;
	vc_mask_t                     ctrl_head_vld;
	flit_ctrl_t [`NIP_VC_NUM-1:0] ctrl_head;
	logic                         sa_rd_en;
	vc_id_t                       sa_rd_vc;
	logic                         st_rd_en;
	vc_id_t                       st_rd_vc;
	flit_t                        st_data;

	// reference model state with one entry per vc
	flit_ctrl_t ctrl_q [`NIP_VC_NUM][$]; // control words not yet popped by sa
	flit_t      data_q [`NIP_VC_NUM][$]; // flits not yet popped by st
	int         credits [`NIP_VC_NUM];
	logic [31:0] lfsr_state;

	tb_clock_gen u_clock_gen (.clk(clk));

	noc_input_port uut (
		.clk             (clk),
		.rst_n_i         (rst_n),
		.rx_flit_v_i     (rx_flit_v),
		.rx_flit_i       (rx_flit),
		.rx_vc_id_i      (rx_vc_id),
		.rx_route_i      (rx_route),
		.lcrd_v_o        (lcrd_v),
		.lcrd_id_o       (lcrd_id),
		.ctrl_head_vld_o (ctrl_head_vld),
		.ctrl_head_o     (ctrl_head),
		.sa_rd_en_i      (sa_rd_en),
		.sa_rd_vc_i      (sa_rd_vc),
		.st_rd_en_i      (st_rd_en),
		.st_rd_vc_i      (st_rd_vc),
		.st_data_o       (st_data)
	);

	// ------------------------------
	// random numbers
	// ------------------------------

	// taps at x^32 + x^22 + x^2 + x + 1 with one step per bit
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			val = {val[30:0], lfsr_bit()};
		end
		return val;
	endfunction

	function automatic flit_t rand_flit();
		flit_t f;
		for (int i = 0; i < `NIP_FLIT_W / 32; i++) begin
			f[i*32 +: 32] = rand_bits(32);
		end
		return f;
	endfunction

	// ------------------------------
	// model helpers
	// ------------------------------

	// each id is the flit shifted down to its lowest header bit and cut to the id width
	function automatic flit_ctrl_t expected_ctrl(input flit_t f, input route_t r);
		flit_ctrl_t c;
		c.dst_id = node_id_t'(f >> `NIP_DST_LSB);
		c.src_id = node_id_t'(f >> `NIP_SRC_LSB);
		c.txn_id = txn_id_t'(f >> `NIP_TXN_LSB);
		c.route  = r;
		c.qos    = qos_t'(f); // the lowest flit bits
		return c;
	endfunction

	function automatic logic pick_send_vc(output vc_id_t vc);
		vc_id_t start;
		start = vc_id_t'(rand_bits(2));
		vc = start;
		for (int i = 0; i < `NIP_VC_NUM; i++) begin
			vc = start + vc_id_t'(i);
			if (credits[vc] > 0) return 1'b1;
		end
		return 1'b0;
	endfunction

	function automatic logic pick_sa_vc(output vc_id_t vc);
		vc_id_t start;
		start = vc_id_t'(rand_bits(2));
		vc = start;
		for (int i = 0; i < `NIP_VC_NUM; i++) begin
			vc = start + vc_id_t'(i);
			if (ctrl_q[vc].size() != 0) return 1'b1;
		end
		return 1'b0;
	endfunction

	// st may only take flits whose control word already left through sa
	function automatic logic pick_st_vc(output vc_id_t vc);
		vc_id_t start;
		start = vc_id_t'(rand_bits(2));
		vc = start;
		for (int i = 0; i < `NIP_VC_NUM; i++) begin
			vc = start + vc_id_t'(i);
			if (data_q[vc].size() > ctrl_q[vc].size()) return 1'b1;
		end
		return 1'b0;
	endfunction

	function automatic logic model_empty();
		for (int v = 0; v < `NIP_VC_NUM; v++) begin
			if (data_q[v].size() != 0) return 1'b0;
		end
		return 1'b1;
	endfunction

	// ------------------------------
	// checks
	// ------------------------------
	task automatic abort_run();
		$display("TEST FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_ctrl(input string name, input flit_ctrl_t got, input flit_ctrl_t exp);
		if (got !== exp) begin
			$display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_flit(input string name, input flit_t got, input flit_t exp);
		if (got !== exp) begin
			$display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_vc(input string name, input vc_id_t got, input vc_id_t exp);
		if (got !== exp) begin
			$display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_mask(input string name, input vc_mask_t got, input vc_mask_t exp);
		if (got !== exp) begin
			$display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
			abort_run();
		end
	endtask

	// ------------------------------
	// one clock cycle
	// ------------------------------
	task automatic run_cycle(input logic snd, input vc_id_t snd_vc, input flit_t flit,
		input route_t route, input logic sa, input vc_id_t sa_vc,
		input logic st, input vc_id_t st_vc);
		vc_mask_t exp_vld;
		@(posedge clk);
		#1;
		rx_flit_v = snd;
		rx_vc_id  = snd_vc;
		rx_flit   = flit;
		rx_route  = route;
		sa_rd_en  = sa;
		sa_rd_vc  = sa_vc;
		st_rd_en  = st;
		st_rd_vc  = st_vc;
		#1; // outputs have settled well clear of the next edge
		for (int v = 0; v < `NIP_VC_NUM; v++) begin
			exp_vld[v] = (ctrl_q[v].size() != 0);
			if (exp_vld[v]) begin
				check_ctrl($sformatf("ctrl_head_o[%0d]", v), ctrl_head[v], ctrl_q[v][0]);
			end
		end
		check_mask("ctrl_head_vld_o", ctrl_head_vld, exp_vld);
		check_bit("lcrd_v_o", lcrd_v, st);
		if (st) begin
			check_vc("lcrd_id_o", lcrd_id, st_vc);
			check_flit("st_data_o", st_data, data_q[st_vc][0]);
		end
		// the model takes the same edge that the dut is about to take
		if (sa) void'(ctrl_q[sa_vc].pop_front());
		if (st) void'(data_q[st_vc].pop_front());
		if (lcrd_v) credits[lcrd_id]++;
		if (snd) begin
			ctrl_q[snd_vc].push_back(expected_ctrl(flit, route));
			data_q[snd_vc].push_back(flit);
			credits[snd_vc]--;
		end
	endtask

	task automatic idle_cycle();
		run_cycle(1'b0, '0, '0, '0, 1'b0, '0, 1'b0, '0);
	endtask

	task automatic wait_head_valid(input vc_id_t vc, input int limit);
		int waited;
		waited = 0;
		while (!ctrl_head_vld[vc]) begin
			if (waited == limit) begin
				$display("timed out waiting for a valid control head on vc %0d", vc);
				abort_run();
			end
			idle_cycle();
			waited++;
		end
	endtask

	// pops whatever is eligible until every vc is empty
	task automatic drain(input int limit);
		int waited;
		logic sa;
		logic st;
		vc_id_t sa_vc;
		vc_id_t st_vc;
		waited = 0;
		while (!model_empty()) begin
			if (waited == limit) begin
				$display("drain did not empty the vc buffers within %0d cycles", limit);
				abort_run();
			end
			sa = pick_sa_vc(sa_vc);
			st = pick_st_vc(st_vc);
			run_cycle(1'b0, '0, '0, '0, sa, sa_vc, st, st_vc);
			waited++;
		end
	endtask

	// ------------------------------
	// stimulus
	// ------------------------------
	initial begin
		logic   snd;
		logic   sa;
		logic   st;
		logic   all_ok;
		vc_id_t snd_vc;
		vc_id_t sa_vc;
		vc_id_t st_vc;
		flit_t  flit;
		route_t route;

		lfsr_state = 32'hf608;
		rst_n      = 1'b0;
		rx_flit_v  = 1'b0;
		rx_flit    = '0;
		rx_vc_id   = '0;
		rx_route   = '0;
		sa_rd_en   = 1'b0;
		sa_rd_vc   = '0;
		st_rd_en   = 1'b0;
		st_rd_vc   = '0;
		snd_vc     = '0;
		sa_vc      = '0;
		st_vc      = '0;
		for (int v = 0; v < `NIP_VC_NUM; v++) begin
			credits[v] = `NIP_VC_DEPTH;
		end

		repeat (16) @(posedge clk);
		#1;
		check_mask("ctrl_head_vld_o", ctrl_head_vld, '0);
		check_bit("lcrd_v_o", lcrd_v, 1'b0);
		rst_n = 1'b1;
		repeat (8) idle_cycle(); // nothing may show up without a write

		// sa runs three words ahead of st on vc 2 while vc 0 keeps filling
		run_cycle(1'b1, 2'd2, rand_flit(), route_t'(0), 1'b0, '0, 1'b0, '0);
		wait_head_valid(2'd2, 8);
		for (int i = 1; i < 3; i++) begin
			run_cycle(1'b1, 2'd2, rand_flit(), route_t'(i), 1'b0, '0, 1'b0, '0);
		end
		for (int i = 0; i < 3; i++) begin
			run_cycle(1'b1, 2'd0, rand_flit(), 3'd5, 1'b1, 2'd2, 1'b0, '0);
		end
		for (int i = 0; i < 3; i++) begin
			run_cycle(1'b0, '0, '0, '0, 1'b0, '0, 1'b1, 2'd2);
		end
		drain(200);

		for (int cyc = 0; cyc < 2000; cyc++) begin
			snd = 1'b0;
			sa  = 1'b0;
			st  = 1'b0;
			if (rand_bits(2) != 0) snd = pick_send_vc(snd_vc);
			flit  = rand_flit();
			route = route_t'(rand_bits(`NIP_ROUTE_W));
			if (rand_bits(1) != 0) sa = pick_sa_vc(sa_vc);
			if (rand_bits(1) != 0) st = pick_st_vc(st_vc);
			run_cycle(snd, snd_vc, flit, route, sa, sa_vc, st, st_vc);
		end
		drain(200);
		repeat (2) idle_cycle();

		all_ok = 1'b1;
		for (int v = 0; v < `NIP_VC_NUM; v++) begin
			if (credits[v] != `NIP_VC_DEPTH || ctrl_q[v].size() != 0) begin
				$display("vc %0d ended with %0d credits and %0d control words left",
					v, credits[v], ctrl_q[v].size());
				all_ok = 1'b0;
			end
		end
		if (all_ok) begin
			$display("TEST PASSED");
			$finish;
		end else begin
			abort_run();
		end
	end

endmodule

`default_nettype wire

// File: noc_input_port.f
+incdir+common
common/noc_input_port_pkg.sv
input_port/flit_decoder.sv
input_port/vc_buffer.sv
input_port/vc_read_ctrl.sv
design/noc_input_port.sv
tb/tb_clock_gen.sv
tb/tb_noc_input_port.sv
